// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_execute_unit
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | awk '{ print } /\*\* PASS \*\*/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(BUILD_DIR)

// File: build.f
+incdir+include
src/alu_pkg.sv
src/alu_core.sv
src/mul_div_unit.sv
src/result_queue.sv
src/execute_unit.sv
testbench/tb_execute_unit.sv

// File: include/alu_config.svh
`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

// Datapath width of the execute stage
`define ALU_WIDTH 32

`define RESULT_DEPTH 4      // Result FIFO entries

`define RESULT_CREDITS 2    // Buffers on the writeback side

`define DIV_CYCLES 32       // One quotient bit per step

`endif

// File: src/alu_core.sv
`timescale 1ns/1ns

module alu_core (
    input  alu_pkg::alu_op_t op,
    input  alu_pkg::word_t   a,
    input  alu_pkg::word_t   b,
    input  alu_pkg::shamt_t  shamt,
    input  alu_pkg::word_t   hi,
    input  alu_pkg::word_t   lo,
    output alu_pkg::word_t   y,
    output logic             zero
);

    alu_pkg::shamt_t var_amt;
    logic            a_neg;
    logic            a_is_zero;
    logic            known_op;

    // Branch convention: 0 when the condition holds, 1 otherwise
    function automatic alu_pkg::word_t branch_res(input logic taken);
        alu_pkg::word_t res;
        res = taken ? '0 : alu_pkg::word_t'(1);
        return res;
    endfunction

    assign var_amt   = a[4:0];              // Only the low five bits count
    assign a_neg     = a[$bits(a)-1];
    assign a_is_zero = (a == '0);
    assign known_op  = (op <= alu_pkg::OP_JR);

    always_comb begin
        case (op)
            alu_pkg::OP_AND: begin
                y = a & b;
            end
            alu_pkg::OP_OR: begin
                y = a | b;
            end
            alu_pkg::OP_XOR: begin
                y = a ^ b;
            end
            alu_pkg::OP_ADDU: begin
                y = a + b;                  // No overflow trap
            end
            alu_pkg::OP_SUBU: begin
                y = a - b;
            end
            alu_pkg::OP_SLTU: begin
                y = alu_pkg::word_t'(a < b);
            end
            alu_pkg::OP_SLT: begin
                y = alu_pkg::word_t'($signed(a) < $signed(b));
            end
            alu_pkg::OP_SLL: begin
                y = b << shamt;
            end
            alu_pkg::OP_SLLV: begin
                y = b << var_amt;
            end
            alu_pkg::OP_SRA: begin
                y = $signed(b) >>> shamt;   // Sign bit fills from the left
            end
            alu_pkg::OP_SRL: begin
                y = b >> shamt;
            end
            alu_pkg::OP_SRAV: begin
                y = $signed(b) >>> var_amt;
            end
            alu_pkg::OP_SRLV: begin
                y = b >> var_amt;
            end
            alu_pkg::OP_MFHI: begin
                y = hi;
            end
            alu_pkg::OP_MFLO: begin
                y = lo;
            end
            alu_pkg::OP_BLTZ: begin
                y = branch_res(a_neg);
            end
            alu_pkg::OP_BGTZ: begin
                y = branch_res(!a_neg && !a_is_zero);
            end
            alu_pkg::OP_BGEZ: begin
                y = branch_res(!a_neg);
            end
            alu_pkg::OP_BNE: begin
                y = branch_res(a != b);
            end
            alu_pkg::OP_BLEZ: begin
                y = branch_res(a_neg || a_is_zero);
            end
            alu_pkg::OP_JR: begin
                y = a;                      // Jump target goes through untouched
            end
            alu_pkg::OP_MULT,
            alu_pkg::OP_MULTU,
            alu_pkg::OP_DIV,
            alu_pkg::OP_DIVU: begin
                // Result lands in HI and LO, read back with MFHI or MFLO
                y = '0;
            end
            default: begin
                y = '0;                     // Unknown code
            end
        endcase
    end

    assign zero = (y == '0);

    // HI and LO come from the multiply/divide unit and must be settled
    always_comb begin
        if (known_op) begin
            assert (!$isunknown(y))
                else $error("alu_core: unknown result for op %b", op);
        end
    end

endmodule

// File: src/alu_pkg.sv
`include "alu_config.svh"

package alu_pkg;

    typedef logic [`ALU_WIDTH-1:0] word_t;
    typedef logic [4:0]            shamt_t;    // Immediate or a[4:0] shift count

    typedef enum logic [4:0] {
        OP_AND   = 5'b00000,
        OP_OR    = 5'b00001,
        OP_XOR   = 5'b00010,
        OP_ADDU  = 5'b00011,
        OP_SUBU  = 5'b00100,
        OP_SLTU  = 5'b00101,
        OP_SLT   = 5'b00110,
        OP_MULTU = 5'b00111,    // Writes HI and LO
        OP_MULT  = 5'b01000,
        OP_SLL   = 5'b01001,
        OP_SLLV  = 5'b01010,
        OP_SRA   = 5'b01011,
        OP_SRL   = 5'b01100,
        OP_SRAV  = 5'b01101,
        OP_SRLV  = 5'b01110,
        OP_DIV   = 5'b01111,
        OP_DIVU  = 5'b10000,
        OP_MFHI  = 5'b10001,
        OP_MFLO  = 5'b10010,
        OP_BLTZ  = 5'b10011,    // Branch codes give 0 when taken
        OP_BGTZ  = 5'b10100,
        OP_BGEZ  = 5'b10101,
        OP_BNE   = 5'b10110,
        OP_BLEZ  = 5'b10111,
        OP_JR    = 5'b11000     // Passes a through
    } alu_op_t;

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_DONE
    } div_state_t;

endpackage

// File: src/execute_unit.sv
`timescale 1ns/1ns

module execute_unit (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             op_valid,
    input  alu_pkg::alu_op_t op,
    input  alu_pkg::word_t   a,
    input  alu_pkg::word_t   b,
    input  alu_pkg::shamt_t  shamt,
    output logic             op_ready,
    output logic             res_valid,
    output alu_pkg::word_t   res_data,
    output logic             res_zero,
    input  logic             res_credit
);

    alu_pkg::word_t alu_y;
    logic           alu_zero;
    alu_pkg::word_t hi;
    alu_pkg::word_t lo;
    logic           md_busy;
    logic           md_start;
    logic [3:0]     q_free;
    logic           q_push;
    logic           accept;
    logic           is_muldiv;

    assign is_muldiv = (op == alu_pkg::OP_MULT) || (op == alu_pkg::OP_MULTU) ||
                       (op == alu_pkg::OP_DIV)  || (op == alu_pkg::OP_DIVU);

    // Stall while HI/LO are being produced or no queue slot is left
    assign op_ready = !md_busy && (q_free != 4'd0);
    assign accept   = op_valid && op_ready;
    assign md_start = accept && is_muldiv;
    assign q_push   = accept && !is_muldiv;     // Every other op yields one result

    alu_core i_alu_core (
        .op    (op),
        .a     (a),
        .b     (b),
        .shamt (shamt),
        .hi    (hi),
        .lo    (lo),
        .y     (alu_y),
        .zero  (alu_zero)
    );

    mul_div_unit i_mul_div_unit (
        .clk   (clk),
        .rst_n (rst_n),
        .start (md_start),
        .op    (op),
        .a     (a),
        .b     (b),
        .hi    (hi),
        .lo    (lo),
        .busy  (md_busy)
    );

    result_queue i_result_queue (
        .clk        (clk),
        .rst_n      (rst_n),
        .push       (q_push),
        .push_data  (alu_y),
        .push_zero  (alu_zero),
        .free       (q_free),
        .res_valid  (res_valid),
        .res_data   (res_data),
        .res_zero   (res_zero),
        .res_credit (res_credit)
    );

endmodule

// File: src/mul_div_unit.sv
`timescale 1ns/1ns
`include "alu_config.svh"

module mul_div_unit (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start,
    input  alu_pkg::alu_op_t op,
    input  alu_pkg::word_t   a,
    input  alu_pkg::word_t   b,
    output alu_pkg::word_t   hi,
    output alu_pkg::word_t   lo,
    output logic             busy
);

    localparam int W     = `ALU_WIDTH;
    localparam int CNT_W = $clog2(`DIV_CYCLES);

    logic                  is_mul;
    logic                  is_signed;

    logic                  mul_pend;        // Product goes to HI/LO next edge
    alu_pkg::word_t        mul_a;
    alu_pkg::word_t        mul_b;
    logic                  mul_sgn;
    logic signed [W:0]     mul_ax;
    logic signed [W:0]     mul_bx;
    logic signed [2*W-1:0] mul_prod;

    alu_pkg::div_state_t   div_state;
    logic [CNT_W-1:0]      div_cnt;
    alu_pkg::word_t        rem;
    alu_pkg::word_t        quo;             // Dividend shifts out, quotient in
    alu_pkg::word_t        dvs;
    logic                  neg_q;
    logic                  neg_r;
    logic                  div_zero;
    logic [W:0]            trial;

    assign is_mul    = (op == alu_pkg::OP_MULT) || (op == alu_pkg::OP_MULTU);
    assign is_signed = (op == alu_pkg::OP_MULT) || (op == alu_pkg::OP_DIV);

    // One extra bit turns both cases into a signed multiply
    assign mul_ax   = {mul_sgn & mul_a[W-1], mul_a};
    assign mul_bx   = {mul_sgn & mul_b[W-1], mul_b};
    assign mul_prod = mul_ax * mul_bx;

    assign trial = {rem, quo[W-1]} - {1'b0, dvs};   // Restoring trial subtract

    assign busy = mul_pend || (div_state != alu_pkg::DIV_IDLE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mul_pend  <= 1'b0;
            div_state <= alu_pkg::DIV_IDLE;
            div_cnt   <= '0;
        end else begin
            mul_pend <= start && is_mul;
            case (div_state)
                alu_pkg::DIV_IDLE: begin
                    if (start && !is_mul) begin
                        div_state <= alu_pkg::DIV_RUN;
                        div_cnt   <= '0;
                    end
                end
                alu_pkg::DIV_RUN: begin
                    div_cnt <= div_cnt + 1'b1;
                    if (div_cnt == CNT_W'(`DIV_CYCLES - 1)) begin
                        div_state <= alu_pkg::DIV_DONE;
                    end
                end
                default: begin
                    div_state <= alu_pkg::DIV_IDLE;     // Sign fix-up cycle
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start && is_mul) begin
            mul_a   <= a;
            mul_b   <= b;
            mul_sgn <= is_signed;
        end
        if (start && !is_mul) begin
            quo      <= (is_signed && a[W-1]) ? -a : a;    // Work on magnitudes
            dvs      <= (is_signed && b[W-1]) ? -b : b;
            rem      <= '0;
            neg_q    <= is_signed && (a[W-1] ^ b[W-1]);
            neg_r    <= is_signed && a[W-1];               // Remainder follows dividend
            div_zero <= (b == '0);
        end else if (div_state == alu_pkg::DIV_RUN) begin
            if (!trial[W]) begin
                rem <= trial[W-1:0];
                quo <= {quo[W-2:0], 1'b1};
            end else begin
                rem <= {rem[W-2:0], quo[W-1]};
                quo <= {quo[W-2:0], 1'b0};
            end
        end
    end

    // With a zero divisor the remainder ends up as |a|, so HI returns a
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hi <= '0;
            lo <= '0;
        end else if (mul_pend) begin
            hi <= mul_prod[2*W-1:W];
            lo <= mul_prod[W-1:0];
        end else if (div_state == alu_pkg::DIV_DONE) begin
            hi <= neg_r ? -rem : rem;
            lo <= div_zero ? '1 : (neg_q ? -quo : quo);
        end
    end

    // Issue logic must hold new work until busy falls
    assert property (@(posedge clk) disable iff (!rst_n) start |-> !busy)
        else $error("mul_div_unit: start while busy");

endmodule

// File: src/result_queue.sv
`timescale 1ns/1ns
`include "alu_config.svh"

module result_queue (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           push,
    input  alu_pkg::word_t push_data,
    input  logic           push_zero,
    output logic [3:0]     free,
    output logic           res_valid,
    output alu_pkg::word_t res_data,
    output logic           res_zero,
    input  logic           res_credit
);

    localparam int PTR_W = $clog2(`RESULT_DEPTH);
    localparam int CNT_W = $clog2(`RESULT_DEPTH + 1);
    localparam int CRD_W = $clog2(`RESULT_CREDITS + 1);

    alu_pkg::word_t   data_mem [`RESULT_DEPTH];
    logic             zero_mem [`RESULT_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CRD_W-1:0] credits;          // Free buffers on the far side

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(`RESULT_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // Head is sent whenever a credit is left
    assign res_valid = (count != '0) && (credits != '0);
    assign res_data  = data_mem[rd_ptr];
    assign res_zero  = zero_mem[rd_ptr];
    assign free      = 4'(`RESULT_DEPTH) - 4'(count);

    always_ff @(posedge clk) begin
        if (push) begin
            data_mem[wr_ptr] <= push_data;
            zero_mem[wr_ptr] <= push_zero;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            credits <= CRD_W'(`RESULT_CREDITS);
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (res_valid) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count   <= count + CNT_W'(push) - CNT_W'(res_valid);
            credits <= credits + CRD_W'(res_credit) - CRD_W'(res_valid);
        end
    end

    // Downstream returns at most what it has received
    assert property (@(posedge clk) disable iff (!rst_n)
                     credits <= CRD_W'(`RESULT_CREDITS))
        else $error("result_queue: credit counter overflow");

    assert property (@(posedge clk) disable iff (!rst_n) push |-> (free != 4'd0))
        else $error("result_queue: push into full queue");

endmodule

// File: testbench/execute_testdata.txt
# op a b shamt expected_y expected_zero check (all fields hex)
# check 0 marks MULT, MULTU, DIV and DIVU, which leave no result entry
00 f0f0f0f0 ff00ff00 00 f000f000 0 1
01 f0f0f0f0 0f0f0f0f 00 ffffffff 0 1
02 12345678 12345678 00 00000000 1 1
03 ffffffff 00000001 00 00000000 1 1
04 00000005 00000007 00 fffffffe 0 1
05 00000001 ffffffff 00 00000001 0 1
06 ffffffff 00000001 00 00000001 0 1
06 00000001 80000000 00 00000000 1 1
09 00000000 00000003 04 00000030 0 1
0a 00000024 00000001 00 00000010 0 1
0b 00000000 80000000 04 f8000000 0 1
0c 00000000 80000000 04 08000000 0 1
0d 0000003f f0000000 00 ffffffff 0 1
0e 00000021 80000000 00 40000000 0 1
08 fffffffe 00000003 00 00000000 0 0
11 00000000 00000000 00 ffffffff 0 1
12 00000000 00000000 00 fffffffa 0 1
07 fffffffe 00000003 00 00000000 0 0
11 00000000 00000000 00 00000002 0 1
12 00000000 00000000 00 fffffffa 0 1
0f fffffff9 00000002 00 00000000 0 0
12 00000000 00000000 00 fffffffd 0 1
11 00000000 00000000 00 ffffffff 0 1
0f 00000007 fffffffe 00 00000000 0 0
12 00000000 00000000 00 fffffffd 0 1
11 00000000 00000000 00 00000001 0 1
10 12345678 00000000 00 00000000 0 0
11 00000000 00000000 00 12345678 0 1
12 00000000 00000000 00 ffffffff 0 1
13 80000000 00000000 00 00000000 1 1
14 00000000 00000000 00 00000001 0 1
15 00000000 00000000 00 00000000 1 1
16 00000005 00000005 00 00000001 0 1
17 00000000 00000000 00 00000000 1 1
18 00400020 00000000 00 00400020 0 1
1b ffffffff ffffffff 00 00000000 1 1
03 00000010 00000020 00 00000030 0 1
02 aaaaaaaa 55555555 00 ffffffff 0 1

// File: testbench/tb_execute_unit.sv
`timescale 1ns/1ns
`include "alu_config.svh"

module tb_execute_unit;

    localparam int    CYCLES_PER_LINE = 50;     // A divide plus some queue drain
    localparam int    EXTRA_CYCLES    = 200;
    localparam string DATA_FILE       = "testbench/execute_testdata.txt";

    logic             clk;
    logic             rst_n;
    logic             op_valid;
    alu_pkg::alu_op_t op;
    alu_pkg::word_t   a;
    alu_pkg::word_t   b;
    alu_pkg::shamt_t  shamt;
    logic             op_ready;
    logic             res_valid;
    alu_pkg::word_t   res_data;
    logic             res_zero;
    logic             res_credit;

    logic [4:0]       line_op [$];
    alu_pkg::word_t   line_a [$];
    alu_pkg::word_t   line_b [$];
    alu_pkg::shamt_t  line_shamt [$];
    alu_pkg::word_t   line_y [$];
    bit               line_zero [$];
    bit               line_chk [$];          // Clear for ops that only write HI and LO

    alu_pkg::word_t   exp_y_q [$];
    bit               exp_zero_q [$];
    int               due_q [$];             // Cycles at which credits go back
    int               n_lines;
    int               n_expected;
    int               n_checked;
    int               sender_credits;        // Mirror of the sender counter
    bit               loaded;

    execute_unit i_execute_unit (
        .clk        (clk),
        .rst_n      (rst_n),
        .op_valid   (op_valid),
        .op         (op),
        .a          (a),
        .b          (b),
        .shamt      (shamt),
        .op_ready   (op_ready),
        .res_valid  (res_valid),
        .res_data   (res_data),
        .res_zero   (res_zero),
        .res_credit (res_credit)
    );

    task automatic stop_with_failure();
        $display("** FAIL **");
        $fatal(1, "execute_unit testbench stopped");
    endtask

    task automatic check_value(input string name, input alu_pkg::word_t actual,
                               input alu_pkg::word_t expected);
        if (actual !== expected) begin
            $display("CHECK FAILED %s actual=%h expected=%h", name, actual, expected);
            stop_with_failure();
        end
    endtask

    // Cycles that op_ready stays low after a multiply or divide is taken
    function automatic int busy_cycles(input logic [4:0] code);
        int cycles;
        case (code)
            alu_pkg::OP_MULT,
            alu_pkg::OP_MULTU: begin
                cycles = 1;
            end
            alu_pkg::OP_DIV,
            alu_pkg::OP_DIVU: begin
                cycles = `DIV_CYCLES + 1;
            end
            default: begin
                cycles = 0;
            end
        endcase
        return cycles;
    endfunction

    task automatic load_testdata();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f_op, f_a, f_b, f_sh, f_y, f_z, f_chk;
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the test data file %s", DATA_FILE);
            stop_with_failure();
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            n    = $sscanf(line, "%h %h %h %h %h %h %h", f_op, f_a, f_b, f_sh, f_y, f_z, f_chk);
            if (n == 7) begin
                line_op.push_back(f_op[4:0]);
                line_a.push_back(f_a);
                line_b.push_back(f_b);
                line_shamt.push_back(f_sh[4:0]);
                line_y.push_back(f_y);
                line_zero.push_back(f_z[0]);
                line_chk.push_back(f_chk[0]);
                n_expected += int'(f_chk[0]);
            end else if (n > 0) begin
                $display("Test data line has the wrong number of fields: %s", line);
                stop_with_failure();
            end
        end
        $fclose(fd);
        n_lines = line_op.size();
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Operation driver
    initial begin
        int stall;
        int want_stall;
        void'($urandom(32'h22e4));
        rst_n      = 1'b0;
        op_valid   = 1'b0;
        op         = alu_pkg::OP_AND;
        a          = '0;
        b          = '0;
        shamt      = '0;
        n_expected = 0;
        n_checked  = 0;
        load_testdata();
        loaded = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_value("op_ready", alu_pkg::word_t'(op_ready), alu_pkg::word_t'(1'b1));
        check_value("res_valid", alu_pkg::word_t'(res_valid), '0);
        for (int i = 0; i < n_lines; i++) begin
            @(negedge clk);
            op_valid = 1'b0;
            stall    = 0;
            while (!op_ready) begin             // Ready only depends on registered state
                @(negedge clk);
                stall++;
            end
            want_stall = (i > 0) ? busy_cycles(line_op[i-1]) : 0;
            if (want_stall > 0) begin
                check_value("op_ready low cycles", alu_pkg::word_t'(stall),
                            alu_pkg::word_t'(want_stall));
            end
            op       = alu_pkg::alu_op_t'(line_op[i]);
            a        = line_a[i];
            b        = line_b[i];
            shamt    = line_shamt[i];
            op_valid = 1'b1;
            if (line_chk[i]) begin
                exp_y_q.push_back(line_y[i]);
                exp_zero_q.push_back(line_zero[i]);
            end
        end
        @(negedge clk);
        op_valid = 1'b0;
        while (n_checked < n_expected) @(posedge clk);
        $display("** PASS **");
        $finish;
    end

    // Result checker and credit return
    initial begin
        int             cycle;
        int             delay;
        int             due;
        int             last_due;
        alu_pkg::word_t exp_y;
        bit             exp_zero;
        cycle          = 0;
        last_due       = 0;
        res_credit     = 1'b0;
        sender_credits = `RESULT_CREDITS;
        forever begin
            @(negedge clk);
            cycle++;
            if (rst_n) begin
                if (res_valid) begin
                    if (sender_credits == 0) begin
                        $display("res_valid was raised with no credit outstanding");
                        stop_with_failure();
                    end
                    if (exp_y_q.size() == 0) begin
                        $display("A result arrived with no operation waiting for it");
                        stop_with_failure();
                    end
                    exp_y    = exp_y_q.pop_front();
                    exp_zero = exp_zero_q.pop_front();
                    check_value("res_data", res_data, exp_y);
                    check_value("res_zero", alu_pkg::word_t'(res_zero),
                                alu_pkg::word_t'(exp_zero));
                    n_checked++;
                    delay = int'($urandom % 6);
                    due   = cycle + 1 + delay;      // Never before the result is taken
                    if (due <= last_due) begin
                        due = last_due + 1;         // One credit per cycle on the wire
                    end
                    last_due = due;
                    due_q.push_back(due);
                end
                if (due_q.size() > 0 && due_q[0] <= cycle) begin
                    res_credit = 1'b1;
                    void'(due_q.pop_front());
                end else begin
                    res_credit = 1'b0;
                end
                sender_credits = sender_credits - int'(res_valid) + int'(res_credit);
            end
        end
    end

    initial begin
        wait (loaded);
        repeat (n_lines * CYCLES_PER_LINE + EXTRA_CYCLES) @(posedge clk);
        $display("Timeout: only %0d of %0d results arrived", n_checked, n_expected);
        stop_with_failure();
    end

endmodule
